/* Makefile */
SIM := obj_dir/Vtb_vic20_loader
SRCS := $(wildcard src/*.sv) $(wildcard verification/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_vic20_loader

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module tb_vic20_loader

clean:
	rm -rf obj_dir sim.log

/* list.f */
src/loader_pkg.sv
src/memmap_pkg.sv
src/rom_image_mapper.sv
src/prg_loader.sv
src/basic_pointer_injector.sv
src/vic20_loader.sv
verification/loader_checker.sv
verification/tb_vic20_loader.sv

/* src/basic_pointer_injector.sv */
/*
 * BASIC pointer injector
 * Writes the program end into the BASIC pointers after a PRG load,
 * then restarts the machine if a cartridge was loaded
 */

`timescale 1ns/1ps

module basic_pointer_injector
    import memmap_pkg::*;
#(
    parameter int INJECT_STEPS = 32
) (
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      prg_active_i,
    input  logic      cart_loaded_i,
    input  cpu_addr_t last_addr_i,
    output logic      inj_we_o,
    output logic      inj_busy_o,
    output logic      force_reset_o,
    output cpu_addr_t inj_addr_o,
    output logic [7:0] inj_data_o
);

    localparam int STEP_W = $clog2(INJECT_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(INJECT_STEPS - 1);

    logic [STEP_W-1:0] step_q;
    logic              prg_active_q;
    logic [2:0]        slot;
    logic              slot_write;

    // Odd steps 1 to 15 each own one pointer byte
    assign slot       = step_q[3:1];
    assign slot_write = step_q[0] && (step_q < STEP_W'(16));

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            step_q        <= '0;
            prg_active_q  <= 1'b0;
            inj_we_o      <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            prg_active_q  <= prg_active_i;
            inj_we_o      <= slot_write;
            force_reset_o <= (step_q == LAST_STEP) && cart_loaded_i;
            if (prg_active_q && !prg_active_i) begin
                step_q <= STEP_W'(1);
            end else if (step_q == LAST_STEP) begin
                step_q <= '0;
            end else if (step_q != '0) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    // Even slots take the low byte
    always_ff @(posedge clk_sys) begin
        inj_addr_o <= BASIC_PTR_ADDR[slot];
        inj_data_o <= slot[0] ? last_addr_i[15:8] : last_addr_i[7:0];
    end

    assign inj_busy_o = (step_q != '0);

    // A new PRG must not start while pointers are still being patched
    a_no_restart: assert property (@(posedge clk_sys) disable iff (reset)
        inj_busy_o |-> !$rose(prg_active_i));

endmodule

/* src/loader_pkg.sv */
/*
 * Download loader definitions
 * Host index codes, download kinds and the PRG header length
 */

package loader_pkg;

    // ========================================
    // Download kinds
    // ========================================

    typedef enum logic [1:0] {
        DL_NONE = 2'd0,
        DL_ROM  = 2'd1,
        DL_PRG  = 2'd2,
        DL_TAP  = 2'd3
    } dl_kind_e;

    // ========================================
    // Host index codes
    // ========================================

    // System ROM bundle
    localparam logic [7:0] IDX_ROM     = 8'h00;
    // PRG and cartridge images, both menu entries
    localparam logic [7:0] IDX_PRG     = 8'h01;
    localparam logic [7:0] IDX_PRG_ALT = 8'h41;
    // Tape image
    localparam logic [7:0] IDX_TAP     = 8'h81;

    // Two-byte little-endian load address in front of PRG data
    localparam int unsigned PRG_HDR_LEN = 2;

endpackage

/* src/memmap_pkg.sv */
/*
 * VIC-20 memory map
 * Address types, ROM region bases, internal RAM ranges and BASIC pointers
 */

package memmap_pkg;

    typedef logic [22:0] mem_addr_t;
    typedef logic [15:0] cpu_addr_t;

    // ========================================
    // ROM image regions in external memory
    // ========================================

    localparam mem_addr_t DRIVE_BASE       = 23'h00_0000;
    localparam mem_addr_t KERNAL_PAL_BASE  = 23'h00_E000;
    // NTSC kernal sits one 64K bank above the PAL one
    localparam mem_addr_t KERNAL_NTSC_BASE = 23'h01_E000;
    localparam mem_addr_t BASIC_BASE       = 23'h00_C000;
    localparam mem_addr_t CHAR_BASE        = 23'h00_8000;

    // Highest address a PRG may write, ROMs start above it
    localparam cpu_addr_t PRG_TOP = 16'hBFFF;

    // TXTTAB end, VARTAB, ARYTAB, STREND and the load end pointer, low byte first
    localparam cpu_addr_t BASIC_PTR_ADDR [0:7] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

    // RAM inside the machine core: low page RAM, main 4K and colour RAM
    function automatic logic is_internal_ram(input cpu_addr_t addr);
        logic low_ram;
        logic main_ram;
        logic colour_ram;
        low_ram    = (addr[15:10] == 6'b000000);
        main_ram   = (addr[15:12] == 4'h1);
        colour_ram = (addr[15:10] == 6'b100101);
        return low_ram || main_ram || colour_ram;
    endfunction

endpackage

/* src/prg_loader.sv */
/*
 * PRG and cartridge loader
 * Parses the load address header and counts store addresses up to BFFF
 */

`timescale 1ns/1ps

module prg_loader
    import loader_pkg::*;
    import memmap_pkg::*;
#(
    parameter cpu_addr_t PRG_RAW_BASE = 16'hA000
) (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        prg_wr_i,
    input  logic        no_load_addr_i,
    input  logic [24:0] dl_offset_i,
    input  logic [7:0]  dl_data_i,
    output logic        prg_store_o,
    output cpu_addr_t   prg_addr_o,
    output cpu_addr_t   last_addr_o,
    output logic        cart_loaded_o
);

    // Autostart cartridges begin at block 5
    localparam cpu_addr_t CART_ADDR = 16'hA000;

    logic      hdr_byte;
    logic      store_q;
    logic      cart_q;
    cpu_addr_t addr_q;
    cpu_addr_t addr_inc;
    cpu_addr_t last_q;

    assign hdr_byte = !no_load_addr_i && (dl_offset_i < 25'(PRG_HDR_LEN));
    // Never climb into the BASIC and kernal ROMs
    assign addr_inc = (addr_q < PRG_TOP) ? addr_q + 16'd1 : addr_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            store_q <= 1'b0;
            cart_q  <= 1'b0;
        end else begin
            store_q <= prg_wr_i && !hdr_byte;
            // New load forgets the previous cartridge
            if (prg_wr_i && (dl_offset_i == '0)) begin
                cart_q <= 1'b0;
            end else if (store_q && (addr_q == CART_ADDR)) begin
                cart_q <= 1'b1;
            end
        end
    end

    // ========================================
    // Address counter
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (prg_wr_i) begin
            if (no_load_addr_i) begin
                addr_q <= (dl_offset_i == '0) ? PRG_RAW_BASE : addr_inc;
            end else if (dl_offset_i == '0) begin
                addr_q[7:0] <= dl_data_i;
            end else if (dl_offset_i == 25'(PRG_HDR_LEN - 1)) begin
                addr_q[15:8] <= dl_data_i;
            end else if (dl_offset_i != 25'(PRG_HDR_LEN)) begin
                // First data byte goes to the load address itself
                addr_q <= addr_inc;
            end
        end
        if (store_q) begin
            last_q <= addr_q;
        end
    end

    assign prg_store_o   = store_q;
    assign prg_addr_o    = addr_q;
    assign last_addr_o   = last_q;
    assign cart_loaded_o = cart_q;

    // Host spaces its strobes, the header path relies on it
    a_wr_spaced: assert property (@(posedge clk_sys) disable iff (reset)
        prg_wr_i |=> !prg_wr_i);

endmodule

/* src/rom_image_mapper.sv */
/*
 * ROM image mapper
 * Places each 8K slice of the ROM bundle at its memory region
 */

`timescale 1ns/1ps

module rom_image_mapper
    import memmap_pkg::*;
(
    input  logic [24:0] dl_offset_i,
    output mem_addr_t   rom_addr_o,
    output logic        rom_internal_o
);

    logic [2:0] slice;
    logic       in_bundle;

    assign slice     = dl_offset_i[15:13];
    // Anything past 64K of the bundle is not a known image
    assign in_bundle = (dl_offset_i[24:16] == 9'd0);

    always_comb begin
        rom_addr_o = '0;
        if (in_bundle) begin
            case (slice)
                // 16K drive ROM spans two slices
                3'b000, 3'b001: rom_addr_o = DRIVE_BASE + mem_addr_t'(dl_offset_i[13:0]);
                3'b010:         rom_addr_o = KERNAL_PAL_BASE + mem_addr_t'(dl_offset_i[12:0]);
                3'b011:         rom_addr_o = KERNAL_NTSC_BASE + mem_addr_t'(dl_offset_i[12:0]);
                3'b100:         rom_addr_o = BASIC_BASE + mem_addr_t'(dl_offset_i[12:0]);
                // Character ROM is only 4K
                3'b101:         rom_addr_o = CHAR_BASE + mem_addr_t'(dl_offset_i[11:0]);
                default:        rom_addr_o = '0;
            endcase
        end
    end

    // Character generator lives inside the core, the rest in external memory
    assign rom_internal_o = in_bundle && (slice == 3'b101);

endmodule

/* src/vic20_loader.sv */
/*
 * VIC-20 download loader
 * Classifies host downloads and merges ROM, PRG, tape and pointer
 * writes into one registered memory write port
 */

`timescale 1ns/1ps

module vic20_loader
    import loader_pkg::*;
    import memmap_pkg::*;
#(
    parameter mem_addr_t TAP_BASE     = 23'h02_0000,
    parameter cpu_addr_t PRG_RAW_BASE = 16'hA000,
    parameter int        INJECT_STEPS = 32
) (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        dl_active_i,
    input  logic        dl_wr_i,
    input  logic        no_load_addr_i,
    input  logic [7:0]  dl_index_i,
    input  logic [24:0] dl_offset_i,
    input  logic [7:0]  dl_data_i,
    output logic        mem_we_o,
    output logic        mem_internal_o,
    output logic        force_reset_o,
    output mem_addr_t   mem_addr_o,
    output logic [7:0]  mem_data_o
);

    dl_kind_e   dl_kind;
    logic       rom_wr;
    logic       tap_wr;
    logic       prg_wr;
    logic       prg_active;
    mem_addr_t  rom_addr;
    logic       rom_internal;
    mem_addr_t  tap_next;
    mem_addr_t  tap_addr_q;
    logic       dl_we_q;
    mem_addr_t  dl_addr_q;
    logic       dl_int_q;
    logic [7:0] data_q;
    logic       prg_store;
    cpu_addr_t  prg_addr;
    cpu_addr_t  last_addr;
    logic       cart_loaded;
    logic       inj_we;
    logic       inj_busy;
    cpu_addr_t  inj_addr;
    logic [7:0] inj_data;

    always_comb begin
        dl_kind = DL_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                IDX_ROM:              dl_kind = DL_ROM;
                IDX_PRG, IDX_PRG_ALT: dl_kind = DL_PRG;
                IDX_TAP:              dl_kind = DL_TAP;
                default:              dl_kind = DL_NONE;
            endcase
        end
    end

    assign prg_active = (dl_kind == DL_PRG);
    assign prg_wr     = dl_wr_i && prg_active;
    assign rom_wr     = dl_wr_i && (dl_kind == DL_ROM);
    assign tap_wr     = dl_wr_i && (dl_kind == DL_TAP);

    rom_image_mapper rom_image_mapper_i (
        .dl_offset_i    (dl_offset_i),
        .rom_addr_o     (rom_addr),
        .rom_internal_o (rom_internal)
    );

    prg_loader #(
        .PRG_RAW_BASE (PRG_RAW_BASE)
    ) prg_loader_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .prg_wr_i       (prg_wr),
        .no_load_addr_i (no_load_addr_i),
        .dl_offset_i    (dl_offset_i),
        .dl_data_i      (dl_data_i),
        .prg_store_o    (prg_store),
        .prg_addr_o     (prg_addr),
        .last_addr_o    (last_addr),
        .cart_loaded_o  (cart_loaded)
    );

    basic_pointer_injector #(
        .INJECT_STEPS (INJECT_STEPS)
    ) basic_pointer_injector_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .prg_active_i  (prg_active),
        .cart_loaded_i (cart_loaded),
        .last_addr_i   (last_addr),
        .inj_we_o      (inj_we),
        .inj_busy_o    (inj_busy),
        .force_reset_o (force_reset_o),
        .inj_addr_o    (inj_addr),
        .inj_data_o    (inj_data)
    );

    // ========================================
    // First stage, ROM and tape
    // ========================================

    // Tape image is stored flat from its base
    assign tap_next = (dl_offset_i == '0) ? TAP_BASE : tap_addr_q + 23'd1;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl_we_q <= 1'b0;
        end else begin
            dl_we_q <= rom_wr || tap_wr;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dl_wr_i) begin
            data_q <= dl_data_i;
        end
        if (tap_wr) begin
            tap_addr_q <= tap_next;
        end
        if (rom_wr) begin
            dl_addr_q <= rom_addr;
            dl_int_q  <= rom_internal;
        end else if (tap_wr) begin
            dl_addr_q <= tap_next;
            dl_int_q  <= 1'b0;
        end
    end

    // ========================================
    // Memory write port
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mem_we_o <= 1'b0;
        end else begin
            mem_we_o <= dl_we_q || prg_store || inj_we;
        end
    end

    // Injection only runs with no download active, so sources never overlap
    always_ff @(posedge clk_sys) begin
        if (inj_busy) begin
            mem_addr_o     <= mem_addr_t'(inj_addr);
            mem_data_o     <= inj_data;
            mem_internal_o <= is_internal_ram(inj_addr);
        end else if (prg_store) begin
            mem_addr_o     <= mem_addr_t'(prg_addr);
            mem_data_o     <= data_q;
            mem_internal_o <= is_internal_ram(prg_addr);
        end else begin
            mem_addr_o     <= dl_addr_q;
            mem_data_o     <= data_q;
            mem_internal_o <= dl_int_q;
        end
    end

    a_we_known: assert property (@(posedge clk_sys) disable iff (reset)
        !$isunknown(mem_we_o));

endmodule

/* verification/loader_checker.sv */
/*
 * Write port checker
 * Compares every memory write with the expected queue in order
 * and counts cartridge reset pulses per test
 */

`timescale 1ns/1ps

module loader_checker
    import memmap_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       mem_we_i,
    input  logic       mem_internal_i,
    input  logic       force_reset_i,
    input  mem_addr_t  mem_addr_i,
    input  logic [7:0] mem_data_i
);

    mem_addr_t  exp_addr[$];
    logic [7:0] exp_data[$];
    logic       exp_internal[$];

    int test_errors    = 0;
    int total_errors   = 0;
    int tests_run      = 0;
    int tests_failed   = 0;
    int writes_checked = 0;
    int resets_seen    = 0;

    // ========================================
    // Interface for the testbench
    // ========================================

    function automatic void expect_write(input mem_addr_t addr, input logic [7:0] data,
                                         input logic internal);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_internal.push_back(internal);
    endfunction

    function automatic int pending();
        return exp_addr.size();
    endfunction

    function automatic int reset_count();
        return resets_seen;
    endfunction

    function automatic int error_count();
        return total_errors + test_errors;
    endfunction

    function automatic void finish_test(input string name, input int resets_expected);
        if (exp_addr.size() != 0) begin
            $display("%s timed out with %0d expected writes never seen", name, exp_addr.size());
            test_errors++;
            exp_addr.delete();
            exp_data.delete();
            exp_internal.delete();
        end
        if (resets_seen != resets_expected) begin
            $display("force_reset_o pulsed %0d times in %s, %0d expected",
                     resets_seen, name, resets_expected);
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        tests_run++;
        total_errors += test_errors;
        test_errors   = 0;
        resets_seen   = 0;
    endfunction

    function automatic void print_summary();
        $display("%0d tests, %0d failed, %0d writes checked, %0d errors",
                 tests_run, tests_failed, writes_checked, total_errors + test_errors);
    endfunction

    // ========================================
    // Port monitor
    // ========================================

    function automatic void compare_write();
        mem_addr_t  addr;
        logic [7:0] data;
        logic       internal;
        if (exp_addr.size() == 0) begin
            $display("Unexpected write of %h to address %h with nothing expected",
                     mem_data_i, mem_addr_i);
            test_errors++;
        end else begin
            addr     = exp_addr.pop_front();
            data     = exp_data.pop_front();
            internal = exp_internal.pop_front();
            writes_checked++;
            if (mem_addr_i !== addr) begin
                $display("MISMATCH mem_addr_o: expected %h, got %h", addr, mem_addr_i);
                test_errors++;
            end
            if (mem_data_i !== data) begin
                $display("MISMATCH mem_data_o: expected %h, got %h", data, mem_data_i);
                test_errors++;
            end
            if (mem_internal_i !== internal) begin
                $display("MISMATCH mem_internal_o at %h: expected %h, got %h",
                         addr, internal, mem_internal_i);
                test_errors++;
            end
        end
    endfunction

    // Sampled mid-cycle, well away from the register updates
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (force_reset_i) begin
                resets_seen++;
            end
            if (mem_we_i) begin
                compare_write();
            end
        end
    end

endmodule

/* verification/tb_vic20_loader.sv */
/*
 * Testbench for the VIC-20 download loader
 * Seeded random ROM, PRG, cartridge and tape downloads against a reference model
 */

`timescale 1ns/1ps

module tb_vic20_loader
    import loader_pkg::*;
    import memmap_pkg::*;
();

    localparam mem_addr_t TAP_BASE     = 23'h02_0000;
    localparam cpu_addr_t PRG_RAW_BASE = 16'hA000;

    logic        clk_sys;
    logic        reset;
    logic        dl_active;
    logic        dl_wr;
    logic        no_load_addr;
    logic [7:0]  dl_index;
    logic [24:0] dl_offset;
    logic [7:0]  dl_data;
    logic        mem_we;
    logic        mem_internal;
    logic        force_reset;
    mem_addr_t   mem_addr;
    logic [7:0]  mem_data;
    logic [31:0] rng_state;

    vic20_loader #(
        .TAP_BASE     (TAP_BASE),
        .PRG_RAW_BASE (PRG_RAW_BASE),
        .INJECT_STEPS (32)
    ) vic20_loader_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active),
        .dl_wr_i        (dl_wr),
        .no_load_addr_i (no_load_addr),
        .dl_index_i     (dl_index),
        .dl_offset_i    (dl_offset),
        .dl_data_i      (dl_data),
        .mem_we_o       (mem_we),
        .mem_internal_o (mem_internal),
        .force_reset_o  (force_reset),
        .mem_addr_o     (mem_addr),
        .mem_data_o     (mem_data)
    );

    loader_checker loader_checker_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .mem_we_i       (mem_we),
        .mem_internal_i (mem_internal),
        .force_reset_i  (force_reset),
        .mem_addr_i     (mem_addr),
        .mem_data_i     (mem_data)
    );

    always #20 clk_sys = ~clk_sys;

    // ========================================
    // Random numbers and reference model
    // ========================================

    function automatic logic [31:0] random_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper bits only, the low LCG bits cycle too fast
    function automatic int unsigned rand_between(input int unsigned lo, input int unsigned hi);
        logic [31:0] w;
        w = random_word();
        return lo + (32'(w[31:8]) % (hi - lo + 1));
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] w;
        w = random_word();
        return w[31:24];
    endfunction

    // Low page, main 4K and colour RAM sit inside the core
    function automatic logic is_internal(input cpu_addr_t addr);
        return (addr <= 16'h03FF) || (addr >= 16'h1000 && addr <= 16'h1FFF) ||
               (addr >= 16'h9400 && addr <= 16'h97FF);
    endfunction

    // ========================================
    // Host side of the download stream
    // ========================================

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic send_byte(input logic [24:0] offset, input logic [7:0] data);
        int unsigned gap;
        gap       = rand_between(3, 6);
        dl_offset = offset;
        dl_data   = data;
        dl_wr     = 1'b1;
        next_cycle();
        dl_wr = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic begin_download(input logic [7:0] index, input logic raw);
        dl_index     = index;
        no_load_addr = raw;
        dl_active    = 1'b1;
        next_cycle();
    endtask

    task automatic end_download();
        dl_active = 1'b0;
        next_cycle();
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (loader_checker_i.pending() != 0 && n < 200) begin
            next_cycle();
            n++;
        end
    endtask

    // Cartridge reset is due within 40 cycles of the end of the download
    task automatic wait_for_reset();
        int n;
        n = 0;
        while (loader_checker_i.reset_count() == 0 && n < 40) begin
            next_cycle();
            n++;
        end
    endtask

    task automatic push_pointer_writes(input cpu_addr_t last);
        int i;
        for (i = 0; i < 8; i++) begin
            loader_checker_i.expect_write(mem_addr_t'(BASIC_PTR_ADDR[i]),
                (i % 2 == 0) ? last[7:0] : last[15:8], is_internal(BASIC_PTR_ADDR[i]));
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic run_rom_test();
        logic [31:0] r;
        logic [24:0] offset;
        mem_addr_t   addr;
        logic [7:0]  data;
        int          region;
        int          i;
        begin_download(IDX_ROM, 1'b0);
        for (region = 0; region < 5; region++) begin
            for (i = 0; i < 3; i++) begin
                r    = random_word();
                data = r[31:24];
                case (region)
                    0: begin
                        offset = 25'(r[13:0]);
                        addr   = DRIVE_BASE + mem_addr_t'(r[13:0]);
                    end
                    1: begin
                        offset = 25'h0_4000 + 25'(r[12:0]);
                        addr   = KERNAL_PAL_BASE + mem_addr_t'(r[12:0]);
                    end
                    2: begin
                        offset = 25'h0_6000 + 25'(r[12:0]);
                        addr   = KERNAL_NTSC_BASE + mem_addr_t'(r[12:0]);
                    end
                    3: begin
                        offset = 25'h0_8000 + 25'(r[12:0]);
                        addr   = BASIC_BASE + mem_addr_t'(r[12:0]);
                    end
                    default: begin
                        offset = 25'h0_A000 + 25'(r[11:0]);
                        addr   = CHAR_BASE + mem_addr_t'(r[11:0]);
                    end
                endcase
                loader_checker_i.expect_write(addr, data, region == 4);
                send_byte(offset, data);
            end
        end
        end_download();
        wait_drained();
        loader_checker_i.finish_test("rom image", 0);
    endtask

    task automatic run_prg_test(input string name, input logic [7:0] index, input logic header,
                                input cpu_addr_t load, input int len, input int resets);
        cpu_addr_t  addr;
        cpu_addr_t  last;
        logic [7:0] data;
        int         k;
        addr = header ? load : PRG_RAW_BASE;
        last = addr;
        begin_download(index, !header);
        for (k = 0; k < len; k++) begin
            if (header && k == 0) begin
                data = load[7:0];
            end else if (header && k == 1) begin
                data = load[15:8];
            end else begin
                data = random_byte();
                loader_checker_i.expect_write(mem_addr_t'(addr), data, is_internal(addr));
                last = addr;
                // Stops at the top of RAM
                if (addr < PRG_TOP) begin
                    addr = addr + 16'd1;
                end
            end
            send_byte(25'(k), data);
        end
        push_pointer_writes(last);
        end_download();
        if (resets != 0) begin
            wait_for_reset();
            wait_drained();
        end else begin
            wait_drained();
            repeat (40) next_cycle();
        end
        loader_checker_i.finish_test(name, resets);
    endtask

    task automatic run_tape_test(input int len);
        logic [7:0] data;
        int         k;
        begin_download(IDX_TAP, 1'b0);
        for (k = 0; k < len; k++) begin
            data = random_byte();
            loader_checker_i.expect_write(TAP_BASE + mem_addr_t'(k), data, 1'b0);
            send_byte(25'(k), data);
        end
        end_download();
        wait_drained();
        repeat (40) next_cycle();
        loader_checker_i.finish_test("tape load", 0);
    endtask

    initial begin
        cpu_addr_t load;
        int        len;
        clk_sys      = 1'b0;
        reset        = 1'b1;
        dl_active    = 1'b0;
        dl_wr        = 1'b0;
        no_load_addr = 1'b0;
        dl_index     = 8'h00;
        dl_offset    = '0;
        dl_data      = 8'h00;
        rng_state    = 32'h5ee9e971;
        repeat (3) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        next_cycle();

        run_rom_test();
        load = 16'h1000 + 16'(rand_between(0, 32'h0F00));
        len  = int'(rand_between(4, 24));
        run_prg_test("prg with header", IDX_PRG, 1'b1, load, len, 0);
        len = int'(rand_between(4, 24));
        run_prg_test("headerless cartridge", IDX_PRG_ALT, 1'b0, PRG_RAW_BASE, len, 1);
        // Enough data bytes to run into BFFF from any start
        load = PRG_TOP - 16'(rand_between(0, 7));
        len  = int'(rand_between(12, 24));
        run_prg_test("prg saturation", IDX_PRG, 1'b1, load, len, 0);
        run_tape_test(int'(rand_between(4, 24)));

        loader_checker_i.print_summary();
        if (loader_checker_i.error_count() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
